// File: fft16_core.f
+incdir+.
fft16_pkg.sv
twiddle_rom.sv
radix4_butterfly.sv
fft_stage.sv
fft16_core.sv
tb_fft16.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_fft16
FILELIST  = fft16_core.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_fft16.sv
`timescale 1ns/1ps
`include "fft16_consts.svh"

module tb_fft16;

   localparam int  TIMEOUT = 100;   // cycles per wait
   localparam real PI      = 3.14159265358979;

   logic              clk;
   logic              rst;
   logic              start_i;
   fft16_pkg::cplx_t  data_in [`FFT_POINTS];
   logic              accept_o;
   logic              valid_o;
   fft16_pkg::cplx_t  data_out [`FFT_POINTS];

   fft16_pkg::cplx_t  exp_out [`FFT_POINTS];
   int                m_re [`FFT_POINTS];   // reference model working frame
   int                m_im [`FFT_POINTS];
   int                seed;

   fft16_core u_dut (
      .clk      (clk),
      .rst      (rst),
      .start_i  (start_i),
      .data_i   (data_in),
      .accept_o (accept_o),
      .valid_o  (valid_o),
      .data_o   (data_out)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic step;
      @(posedge clk);
      #1;   // outputs settled, inputs change here
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got %h, expected %h", name, got, exp);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic fail_timeout(input string what);
      $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   function automatic int wrap16(input int v);
      logic signed [15:0] t;
      t = v[15:0];
      return int'(t);
   endfunction

   function automatic int q14(input real x);
      real s;
      s = x * 16384.0;
      if (s >= 0.0) begin
         return $rtoi(s + 0.5);
      end else begin
         return $rtoi(s - 0.5);
      end
   endfunction

   function automatic fft16_pkg::cplx_t make_cplx(input int re, input int im);
      logic [15:0] r;
      logic [15:0] i;
      r = re[15:0];
      i = im[15:0];
      return {r, i};
   endfunction

   // one radix-4 pass on m_re/m_im, in place per group
   task automatic model_pass(input int stride, input bit twiddle);
      int base;
      int ar [4];
      int ai [4];
      int sr;
      int si;
      int c;
      int s;
      int t_re;
      int t_im;
      for (int g = 0; g < 4; g++) begin
         base = (stride == 1) ? 4 * g : g;
         for (int m = 0; m < 4; m++) begin
            ar[m] = m_re[base + m * stride];
            ai[m] = m_im[base + m * stride];
         end
         for (int k = 0; k < 4; k++) begin
            sr = 0;
            si = 0;
            for (int m = 0; m < 4; m++) begin
               case ((m * k) % 4)   // power of -j
                  0: begin
                     sr += ar[m];
                     si += ai[m];
                  end
                  1: begin
                     sr += ai[m];
                     si -= ar[m];
                  end
                  2: begin
                     sr -= ar[m];
                     si -= ai[m];
                  end
                  default: begin
                     sr -= ai[m];
                     si += ar[m];
                  end
               endcase
            end
            sr = wrap16(sr);
            si = wrap16(si);
            if (twiddle) begin
               c    = q14($cos(2.0 * PI * real'(g * k) / 16.0));
               s    = q14($sin(2.0 * PI * real'(g * k) / 16.0));
               t_re = wrap16((sr * c + si * s) >>> 14);
               t_im = wrap16((si * c - sr * s) >>> 14);
               sr   = t_re;
               si   = t_im;
            end
            m_re[base + k * stride] = sr;
            m_im[base + k * stride] = si;
         end
      end
   endtask

   task automatic model_fft;
      fft16_pkg::sample_t t;
      for (int n = 0; n < `FFT_POINTS; n++) begin
         t = data_in[n][31:16];
         m_re[n] = t;
         t = data_in[n][15:0];
         m_im[n] = t;
      end
      model_pass(4, 1'b1);
      model_pass(1, 1'b0);
      for (int k1 = 0; k1 < 4; k1++) begin
         for (int k0 = 0; k0 < 4; k0++) begin
            exp_out[k1 + 4 * k0] = make_cplx(m_re[4 * k1 + k0], m_im[4 * k1 + k0]);
         end
      end
   endtask

   task automatic wait_accept;
      int cycles;
      cycles = 0;
      while (accept_o !== 1'b1) begin
         if (cycles == TIMEOUT) begin
            fail_timeout("accept_o after start_i");
         end else begin
            step();
            cycles++;
         end
      end
   endtask

   task automatic wait_valid(output int accepts);
      int cycles;
      cycles  = 0;
      accepts = 0;
      while (valid_o !== 1'b1) begin
         if (cycles == TIMEOUT) begin
            fail_timeout("valid_o after accept_o");
         end else begin
            step();
            cycles++;
            if (accept_o === 1'b1) accepts++;
         end
      end
   endtask

   task automatic compare_outputs;
      for (int n = 0; n < `FFT_POINTS; n++) begin
         check_val($sformatf("data_o[%0d]", n), data_out[n], exp_out[n]);
      end
   endtask

   // one frame against exp_out, optionally with a second start mid frame
   task automatic run_frame(input bit restart);
      int accepts;
      start_i = 1'b1;
      step();
      start_i = 1'b0;
      wait_accept();
      step();
      check_val("accept_o", accept_o, 1'b0);
      if (restart) begin
         repeat (3) step();
         start_i = 1'b1;
         for (int n = 0; n < `FFT_POINTS; n++) begin
            data_in[n] = make_cplx($random(seed) % 2048, $random(seed) % 2048);
         end
         step();
         start_i = 1'b0;
         check_val("accept_o", accept_o, 1'b0);
      end
      wait_valid(accepts);
      check_val("accept_o extra pulses", accepts, 0);
      compare_outputs();
      step();
      check_val("valid_o", valid_o, 1'b0);
      compare_outputs();   // data_o holds
   endtask

   task automatic idle_after_reset;
      repeat (10) begin
         step();
         check_val("accept_o", accept_o, 1'b0);
         check_val("valid_o", valid_o, 1'b0);
      end
   endtask

   task automatic impulse_frame;
      for (int n = 0; n < `FFT_POINTS; n++) begin
         data_in[n] = '0;
         exp_out[n] = make_cplx(1000, 0);
      end
      data_in[0] = make_cplx(1000, 0);
      run_frame(1'b0);
   endtask

   task automatic constant_frame;
      for (int n = 0; n < `FFT_POINTS; n++) begin
         data_in[n] = make_cplx(100, -50);
         exp_out[n] = '0;
      end
      exp_out[0] = make_cplx(1600, -800);
      run_frame(1'b0);
   endtask

   task automatic random_frames;
      repeat (10) begin
         for (int n = 0; n < `FFT_POINTS; n++) begin
            data_in[n] = make_cplx($random(seed) % 2048, $random(seed) % 2048);
         end
         model_fft();
         run_frame(1'b0);
      end
   endtask

   task automatic restart_while_busy;
      for (int n = 0; n < `FFT_POINTS; n++) begin
         data_in[n] = make_cplx($random(seed) % 2048, $random(seed) % 2048);
      end
      model_fft();
      run_frame(1'b1);
      repeat (30) begin   // no second frame may follow
         step();
         check_val("valid_o", valid_o, 1'b0);
         check_val("accept_o", accept_o, 1'b0);
      end
   endtask

   initial begin
      seed    = 32'he2d8fe0f;
      rst     = 1'b0;
      start_i = 1'b0;
      for (int n = 0; n < `FFT_POINTS; n++) begin
         data_in[n] = '0;
      end
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b1;

      idle_after_reset();
      impulse_frame();
      constant_frame();
      random_frames();
      restart_while_busy();

      $display("Simulation passed");
      $finish;
   end

endmodule

// File: fft16_core.sv
`timescale 1ns/1ps
`include "fft16_consts.svh"

module fft16_core (
   input  logic              clk,
   input  logic              rst,
   input  logic              start_i,
   input  fft16_pkg::cplx_t  data_i [`FFT_POINTS],
   output logic              accept_o,
   output logic              valid_o,
   output fft16_pkg::cplx_t  data_o [`FFT_POINTS]
);

   fft16_pkg::fft_state_t  state;
   fft16_pkg::cplx_t       in_q [`FFT_POINTS];
   fft16_pkg::cplx_t       p1_frame [`FFT_POINTS];
   fft16_pkg::cplx_t       p2_frame [`FFT_POINTS];
   logic                   p1_done;
   logic                   p2_start;
   logic                   p2_done;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state    <= fft16_pkg::IDLE;
         accept_o <= 1'b0;
         p2_start <= 1'b0;
         valid_o  <= 1'b0;
      end else begin
         accept_o <= 1'b0;
         p2_start <= 1'b0;
         valid_o  <= 1'b0;
         case (state)
            fft16_pkg::IDLE: begin
               if (start_i) begin
                  accept_o <= 1'b1;   // doubles as pass 1 start
                  state    <= fft16_pkg::PASS1;
               end
            end
            fft16_pkg::PASS1: begin
               if (p1_done) begin
                  p2_start <= 1'b1;
                  state    <= fft16_pkg::PASS2;
               end
            end
            fft16_pkg::PASS2: begin
               if (p2_done) begin
                  state <= fft16_pkg::OUTPUT;
               end
            end
            fft16_pkg::OUTPUT: begin
               valid_o <= 1'b1;
               state   <= fft16_pkg::IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if ((state == fft16_pkg::IDLE) && start_i) begin
         in_q <= data_i;
      end
      // digit reversal, X[k1 + 4*k0] sits at 4*k1 + k0
      if (state == fft16_pkg::OUTPUT) begin
         for (int k1 = 0; k1 < `FFT_RADIX; k1++) begin
            for (int k0 = 0; k0 < `FFT_RADIX; k0++) begin
               data_o[k1 + `FFT_RADIX * k0] <= p2_frame[`FFT_RADIX * k1 + k0];
            end
         end
      end
   end

   fft_stage #(
      .STRIDE (4)
   ) u_pass1 (
      .clk     (clk),
      .rst     (rst),
      .start_i (accept_o),
      .frame_i (in_q),
      .done_o  (p1_done),
      .frame_o (p1_frame)
   );

   fft_stage #(
      .STRIDE (1)
   ) u_pass2 (
      .clk     (clk),
      .rst     (rst),
      .start_i (p2_start),
      .frame_i (p1_frame),
      .done_o  (p2_done),
      .frame_o (p2_frame)
   );

endmodule

// File: fft_stage.sv
`timescale 1ns/1ps
`include "fft16_consts.svh"

module fft_stage #(
   parameter int STRIDE = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              start_i,
   input  fft16_pkg::cplx_t  frame_i [`FFT_POINTS],
   output logic              done_o,
   output fft16_pkg::cplx_t  frame_o [`FFT_POINTS]
);

   fft16_pkg::cplx_t       buf_q [`FFT_POINTS];
   fft16_pkg::cplx_t       bf_a [`FFT_RADIX];
   fft16_pkg::cplx_t       bf_y [`FFT_RADIX];
   fft16_pkg::grp_idx_t    iss_cnt;
   fft16_pkg::grp_idx_t    wr_cnt;
   fft16_pkg::point_idx_t  rd_base;
   fft16_pkg::point_idx_t  wr_base;
   logic                   issuing;
   logic                   bf_vld;

   // stride 4 groups start at g, stride 1 groups at 4g
   assign rd_base = (STRIDE == 1) ? {iss_cnt, 2'b00} : {2'b00, iss_cnt};
   assign wr_base = (STRIDE == 1) ? {wr_cnt, 2'b00} : {2'b00, wr_cnt};

   for (genvar m = 0; m < `FFT_RADIX; m++) begin : g_rd
      assign bf_a[m] = buf_q[rd_base + fft16_pkg::point_idx_t'(m * STRIDE)];
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         issuing <= 1'b0;
         iss_cnt <= '0;
         wr_cnt  <= '0;
         done_o  <= 1'b0;
      end else begin
         if (start_i) begin
            issuing <= 1'b1;
            iss_cnt <= '0;
         end else if (issuing) begin
            iss_cnt <= iss_cnt + 1'b1;
            if (iss_cnt == 2'd3) begin
               issuing <= 1'b0;   // four groups out
            end
         end

         // results come back in issue order
         if (bf_vld) begin
            wr_cnt <= wr_cnt + 1'b1;
         end
         done_o <= bf_vld && (wr_cnt == 2'd3);
      end
   end

   always_ff @(posedge clk) begin
      if (start_i) begin
         buf_q <= frame_i;
      end
      if (bf_vld) begin
         for (int k = 0; k < `FFT_RADIX; k++) begin
            frame_o[wr_base + fft16_pkg::point_idx_t'(k * STRIDE)] <= bf_y[k];
         end
      end
   end

   radix4_butterfly #(
      .TWIDDLE (STRIDE > 1)
   ) u_bfly (
      .clk     (clk),
      .rst     (rst),
      .valid_i (issuing),
      .a_i     (bf_a),
      .group_i (iss_cnt),
      .valid_o (bf_vld),
      .y_o     (bf_y)
   );

endmodule

// File: radix4_butterfly.sv
`timescale 1ns/1ps
`include "fft16_consts.svh"

module radix4_butterfly #(
   parameter bit TWIDDLE = 1'b1
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 valid_i,
   input  fft16_pkg::cplx_t     a_i [`FFT_RADIX],
   input  fft16_pkg::grp_idx_t  group_i,
   output logic                 valid_o,
   output fft16_pkg::cplx_t     y_o [`FFT_RADIX]
);

   fft16_pkg::sample_t       re [`FFT_RADIX];
   fft16_pkg::sample_t       im [`FFT_RADIX];
   fft16_pkg::cplx_t         sum_q [`FFT_RADIX];
   fft16_pkg::cplx_t         tw_y [`FFT_RADIX];
   fft16_pkg::grp_idx_t      grp_q;
   logic [`BFLY_LATENCY-1:0] vld_q;

   for (genvar m = 0; m < `FFT_RADIX; m++) begin : g_split
      assign re[m] = a_i[m][2*`SAMPLE_W-1:`SAMPLE_W];
      assign im[m] = a_i[m][`SAMPLE_W-1:0];
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[`BFLY_LATENCY-2:0], valid_i};
      end
   end

   assign valid_o = vld_q[`BFLY_LATENCY-1];

   // stage 1, four point dft with factors (-j)^(m*k)
   always_ff @(posedge clk) begin
      if (valid_i) begin
         sum_q[0] <= {re[0] + re[1] + re[2] + re[3], im[0] + im[1] + im[2] + im[3]};
         sum_q[1] <= {re[0] + im[1] - re[2] - im[3], im[0] - re[1] - im[2] + re[3]};
         sum_q[2] <= {re[0] - re[1] + re[2] - re[3], im[0] - im[1] + im[2] - im[3]};
         sum_q[3] <= {re[0] - im[1] - re[2] + im[3], im[0] + re[1] - im[2] - re[3]};
         grp_q    <= group_i;
      end
   end

   if (TWIDDLE) begin : g_tw
      assign tw_y[0] = sum_q[0];   // W^0

      for (genvar k = 1; k < `FFT_RADIX; k++) begin : g_k
         fft16_pkg::tw_exp_t           tw_exp;
         fft16_pkg::twiddle_t          tw_cos;
         fft16_pkg::twiddle_t          tw_sin;
         fft16_pkg::sample_t           s_re;
         fft16_pkg::sample_t           s_im;
         logic signed [2*`SAMPLE_W:0]  p_re;
         logic signed [2*`SAMPLE_W:0]  p_im;

         assign tw_exp = fft16_pkg::tw_exp_t'(grp_q) * fft16_pkg::tw_exp_t'(k);
         assign s_re   = sum_q[k][2*`SAMPLE_W-1:`SAMPLE_W];
         assign s_im   = sum_q[k][`SAMPLE_W-1:0];

         twiddle_rom u_rom (
            .exp_i (tw_exp),
            .cos_o (tw_cos),
            .sin_o (tw_sin)
         );

         // multiply by cos - j*sin
         assign p_re = s_re * tw_cos + s_im * tw_sin;
         assign p_im = s_im * tw_cos - s_re * tw_sin;

         assign tw_y[k] = {p_re[`TWIDDLE_FRAC +: `SAMPLE_W],
                           p_im[`TWIDDLE_FRAC +: `SAMPLE_W]};   // >>> 14
      end
   end else begin : g_plain
      assign tw_y = sum_q;
   end

   // stage 2
   always_ff @(posedge clk) begin
      if (vld_q[0]) begin
         y_o <= tw_y;
      end
   end

endmodule

// File: twiddle_rom.sv
`timescale 1ns/1ps

module twiddle_rom (
   input  fft16_pkg::tw_exp_t   exp_i,
   output fft16_pkg::twiddle_t  cos_o,
   output fft16_pkg::twiddle_t  sin_o
);

   // cos and sin of 2*pi*e/16, scaled by 2**14 and rounded
   always_comb begin
      case (exp_i)
         4'd0:  {cos_o, sin_o} = {16'sd16384, 16'sd0};
         4'd1:  {cos_o, sin_o} = {16'sd15137, 16'sd6270};
         4'd2:  {cos_o, sin_o} = {16'sd11585, 16'sd11585};
         4'd3:  {cos_o, sin_o} = {16'sd6270, 16'sd15137};
         4'd4:  {cos_o, sin_o} = {16'sd0, 16'sd16384};
         4'd5:  {cos_o, sin_o} = {-16'sd6270, 16'sd15137};
         4'd6:  {cos_o, sin_o} = {-16'sd11585, 16'sd11585};
         4'd7:  {cos_o, sin_o} = {-16'sd15137, 16'sd6270};
         4'd8:  {cos_o, sin_o} = {-16'sd16384, 16'sd0};
         4'd9:  {cos_o, sin_o} = {-16'sd15137, -16'sd6270};
         4'd10: {cos_o, sin_o} = {-16'sd11585, -16'sd11585};
         4'd11: {cos_o, sin_o} = {-16'sd6270, -16'sd15137};
         4'd12: {cos_o, sin_o} = {16'sd0, -16'sd16384};
         4'd13: {cos_o, sin_o} = {16'sd6270, -16'sd15137};
         4'd14: {cos_o, sin_o} = {16'sd11585, -16'sd11585};
         default: {cos_o, sin_o} = {16'sd15137, -16'sd6270};   // e = 15
      endcase
   end

endmodule

// File: fft16_pkg.sv
`include "fft16_consts.svh"

package fft16_pkg;

   typedef logic signed [`SAMPLE_W-1:0]         sample_t;     // one re or im component
   typedef logic [2*`SAMPLE_W-1:0]              cplx_t;       // {re, im}
   typedef logic signed [`SAMPLE_W-1:0]         twiddle_t;    // q2.14
   typedef logic [$clog2(`FFT_POINTS)-1:0]      point_idx_t;
   typedef logic [3:0]                          tw_exp_t;     // angle 2*pi*e/16
   typedef logic [1:0]                          grp_idx_t;

   typedef enum logic [1:0] {
      IDLE,
      PASS1,
      PASS2,
      OUTPUT
   } fft_state_t;

endpackage

// File: fft16_consts.svh
`ifndef FFT16_CONSTS_SVH
`define FFT16_CONSTS_SVH

// frame and butterfly geometry
`define FFT_POINTS   16
`define FFT_RADIX    4

// fixed point format
`define SAMPLE_W     16   // bits per re or im component
`define TWIDDLE_FRAC 14   // twiddle 1.0 = 2**14

// cycles from butterfly valid_i to valid_o
`define BFLY_LATENCY 2

`endif
